// File: all.f
+incdir+common
common/fetch_pkg.sv
hw/sync_queue.sv
hw/bimodal_predictor.sv
fetch/pre_decoder.sv
fetch/fetch_ctrl.sv
hw/fetch_top.sv
bench/tb_imem.sv
bench/tb_fetch.sv

// File: bench/tb_fetch.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module tb_fetch;

    localparam int run_cycles = 6000;
    localparam int depth = `FETCH_QUEUE_DEPTH;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [3:0]              mem_rnd;
    logic                    mem_req_valid;
    fetch_pkg::addr_t        mem_req_addr;
    logic                    mem_req_ready;
    logic                    mem_resp_valid;
    fetch_pkg::inst_t        mem_resp_inst;
    fetch_pkg::addr_t        mem_resp_addr;
    logic                    out_valid;
    logic                    out_ready;
    fetch_pkg::fetch_entry_t out_entry;
    fetch_pkg::redirect_t    redirect;
    fetch_pkg::br_update_t   br_update;

    logic [31:0]              lfsr;
    logic [1:0]               model_ctr [1 << `BP_INDEX_BITS];
    // {predicted taken, inst id} for each entry written to the queue
    logic [`FETCH_IID_BITS:0] pending [$];
    fetch_pkg::addr_t         exp_addr;
    fetch_pkg::addr_t         last_branch_pc;
    fetch_pkg::iid_t          next_id;
    logic                     in_flight;
    logic                     drop_next;
    logic                     req_seen;
    int                       n_out;
    int                       n_taken;
    int                       max_occ;
    int                       idle;

    fetch_top i_dut (.*);

    tb_imem i_mem (
        .clk        (clk),
        .rst        (rst),
        .rnd        (mem_rnd),
        .req_valid  (mem_req_valid),
        .req_addr   (mem_req_addr),
        .req_ready  (mem_req_ready),
        .resp_valid (mem_resp_valid),
        .resp_inst  (mem_resp_inst),
        .resp_addr  (mem_resp_addr)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic fetch_pkg::addr_t next_fetch_addr(input fetch_pkg::addr_t pc,
                                                         input fetch_pkg::inst_t w,
                                                         input logic taken);
        if (w[6:0] == `OPCODE_JAL) begin
            return pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        if (w[6:0] == `OPCODE_BRANCH && taken) begin
            return pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        return pc + 32'd4;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // drives one clock of stimulus
    // calm holds off redirects, stalls and training
    task automatic drive_inputs(input int cyc, input logic calm);
        logic hold;
        logic phase_taken;
        hold = !calm && ((cyc % 500) >= 440);
        phase_taken = ((cyc / 1000) % 2) == 0;
        @(posedge clk);
        mem_rnd <= 4'(rand_bits(4));
        out_ready <= !hold && (rand_bits(2) != 2'b00);
        redirect.valid <= !calm && !hold && (rand_bits(6) == 6'd0);
        redirect.addr <= rand_bits(1) ? last_branch_pc : {20'h0, 10'(rand_bits(10)), 2'b00};
        br_update.valid <= !calm && (rand_bits(2) == 2'd0);
        br_update.pc <= last_branch_pc;
        br_update.taken <= phase_taken ? (rand_bits(2) != 2'd0) : (rand_bits(2) == 2'd0);
    endtask

    // reference model updated on every edge
    always @(posedge clk) begin
        logic [`FETCH_IID_BITS:0]  rec;
        logic [`BP_INDEX_BITS-1:0] idx;
        logic                      wrote;
        int                        occ;
        if (rst) begin
            for (int i = 0; i < (1 << `BP_INDEX_BITS); i++) begin
                model_ctr[i] = 2'b01;
            end
            pending.delete();
            exp_addr = `FETCH_RESET_PC;
            next_id = '0;
            in_flight = 1'b0;
            drop_next = 1'b0;
            n_out = 0;
            n_taken = 0;
            max_occ = 0;
            idle = 0;
            req_seen <= 1'b0;
            last_branch_pc <= `FETCH_RESET_PC;
        end else begin
            occ = pending.size();
            wrote = mem_resp_valid && !redirect.valid && !drop_next;
            // the queue is readable exactly when the model holds entries
            check_equal("out_valid", out_valid, occ != 0);
            if (out_valid && out_ready) begin
                rec = pending.pop_front();
                check_equal("out_entry.addr", out_entry.addr, exp_addr);
                check_equal("out_entry.inst", out_entry.inst,
                            i_mem.image_word(out_entry.addr));
                check_equal("out_entry.inst_id", out_entry.inst_id,
                            rec[`FETCH_IID_BITS-1:0]);
                exp_addr = next_fetch_addr(out_entry.addr, out_entry.inst,
                                           rec[`FETCH_IID_BITS]);
                if (out_entry.inst[6:0] == `OPCODE_BRANCH && rec[`FETCH_IID_BITS]) begin
                    n_taken++;
                end
                n_out++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > 300) begin
                stop_run("no entry reached the decode side for 300 cycles");
            end
            if (mem_req_valid && mem_req_ready) begin
                check_equal("queue room at request", (occ + wrote) < depth, 1'b1);
                if (!req_seen) begin
                    check_equal("mem_req_addr", mem_req_addr, `FETCH_RESET_PC);
                end
                req_seen <= 1'b1;
            end
            if (mem_resp_valid) begin
                if (wrote) begin
                    // counter as it stood before this edge's update
                    idx = mem_resp_addr[`BP_INDEX_BITS+1:2];
                    pending.push_back({model_ctr[idx][1], next_id});
                    next_id = next_id + 1'b1;
                    if (mem_resp_inst[6:0] == `OPCODE_BRANCH) begin
                        last_branch_pc <= mem_resp_addr;
                    end
                end
                in_flight = 1'b0;
                drop_next = 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                in_flight = 1'b1;
            end
            if (redirect.valid) begin
                pending.delete();
                exp_addr = redirect.addr;
                drop_next = in_flight;
            end
            if (pending.size() > max_occ) begin
                max_occ = pending.size();
            end
            if (br_update.valid) begin
                idx = br_update.pc[`BP_INDEX_BITS+1:2];
                if (br_update.taken && model_ctr[idx] != 2'b11) begin
                    model_ctr[idx] = model_ctr[idx] + 2'b01;
                end else if (!br_update.taken && model_ctr[idx] != 2'b00) begin
                    model_ctr[idx] = model_ctr[idx] - 2'b01;
                end
            end
        end
    end

    initial begin
        int waited;
        lfsr = 32'hc49e_3f0b;
        rst = 1'b1;
        mem_rnd = '0;
        out_ready = 1'b0;
        redirect = '0;
        br_update = '0;
        repeat (15) begin
            @(negedge clk);
            check_equal("mem_req_valid", mem_req_valid, 1'b0);
            check_equal("out_valid", out_valid, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        while (!req_seen) begin
            if (waited == 100) begin
                stop_run("no fetch request was accepted after reset");
            end else begin
                drive_inputs(0, 1'b1);
                waited++;
            end
        end
        for (int cyc = 0; cyc < run_cycles; cyc++) begin
            drive_inputs(cyc, 1'b0);
        end
        if (n_out < 500 || max_occ != depth || n_taken == 0) begin
            stop_run($sformatf("too little activity: %0d entries, peak fill %0d, %0d taken",
                               n_out, max_occ, n_taken));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: bench/tb_imem.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module tb_imem (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  rnd,
    input  logic        req_valid,
    input  logic [31:0] req_addr,
    output logic        req_ready,
    output logic        resp_valid,
    output logic [31:0] resp_inst,
    output logic [31:0] resp_addr
);

    logic        busy;
    logic [1:0]  left;
    logic [31:0] addr;

    // program image, a hash of the address picks jal, branch or alu op
    function automatic logic [31:0] image_word(input logic [31:0] a);
        logic [31:0] h;
        logic [31:0] imm;
        h = (a ^ 32'h5bd1_e995) * 32'h2c1b_3c6d;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        // byte offsets from -64 to +60
        imm = {{26{h[20]}}, h[19:16], 2'b00};
        if (h[2:0] == 3'd0) begin
            return {imm[20], imm[10:1], imm[11], imm[19:12], h[11:7], `OPCODE_JAL};
        end else if (h[2:0] <= 3'd2) begin
            return {imm[12], imm[10:5], h[31:27], h[26:22], h[14:12], imm[4:1], imm[11],
                    `OPCODE_BRANCH};
        end
        return {h[31:7], 7'b0010011};
    endfunction

    initial begin
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_inst  = '0;
        resp_addr  = '0;
    end

    // latency of 1 to 4 cycles from rnd[1:0], ready from rnd[3:2]
    always @(posedge clk) begin
        if (rst) begin
            req_ready  <= 1'b0;
            resp_valid <= 1'b0;
            busy       <= 1'b0;
        end else begin
            req_ready  <= (rnd[3:2] != 2'b00);
            resp_valid <= 1'b0;
            if (req_valid && req_ready) begin
                addr <= req_addr;
                left <= rnd[1:0];
                busy <= (rnd[1:0] != 2'd0);
                if (rnd[1:0] == 2'd0) begin
                    resp_valid <= 1'b1;
                    resp_inst  <= image_word(req_addr);
                    resp_addr  <= req_addr;
                end
            end else if (busy) begin
                left <= left - 2'd1;
                if (left == 2'd1) begin
                    busy       <= 1'b0;
                    resp_valid <= 1'b1;
                    resp_inst  <= image_word(addr);
                    resp_addr  <= addr;
                end
            end
        end
    end

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      mem_req_valid,
    output fetch_pkg::addr_t          mem_req_addr,
    input  logic                      mem_req_ready,
    input  logic                      mem_resp_valid,
    input  fetch_pkg::inst_t          mem_resp_inst,
    output logic                      out_valid,
    output fetch_pkg::fetch_entry_t   out_entry,
    input  logic                      out_ready,
    input  fetch_pkg::redirect_t      redirect,
    input  fetch_pkg::br_update_t     br_update
);

    fetch_pkg::addr_t        resp_pc;
    fetch_pkg::inst_t        resp_inst;
    fetch_pkg::decode_info_t decode;
    logic                    predict_taken;
    logic                    q_write;
    logic                    q_kill;
    fetch_pkg::fetch_entry_t q_entry;

    logic [$clog2(`FETCH_QUEUE_DEPTH + 1)-1:0] queue_count;

    fetch_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_inst  (mem_resp_inst),
        .redirect       (redirect),
        .decode         (decode),
        .predict_taken  (predict_taken),
        .queue_count    (queue_count),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .resp_pc        (resp_pc),
        .resp_inst      (resp_inst),
        .q_write        (q_write),
        .q_entry        (q_entry),
        .q_kill         (q_kill)
    );

    pre_decoder i_predec (
        .pc   (resp_pc),
        .inst (resp_inst),
        .info (decode)
    );

    // looked up with the pc of the returning fetch
    bimodal_predictor i_bp (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (resp_pc),
        .update        (br_update),
        .predict_taken (predict_taken)
    );

    sync_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) i_queue (
        .clk        (clk),
        .rst        (rst),
        .kill       (q_kill),
        .write      (q_write),
        .wdata      (q_entry),
        .read_ready (out_ready),
        .read_valid (out_valid),
        .rdata      (out_entry),
        .count      (queue_count)
    );

endmodule

// File: fetch/fetch_ctrl.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_ctrl (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        mem_req_ready,
    input  logic                                        mem_resp_valid,
    input  fetch_pkg::inst_t                            mem_resp_inst,
    input  fetch_pkg::redirect_t                        redirect,
    input  fetch_pkg::decode_info_t                     decode,
    input  logic                                        predict_taken,
    input  logic [$clog2(`FETCH_QUEUE_DEPTH + 1)-1:0]   queue_count,
    output logic                                        mem_req_valid,
    output fetch_pkg::addr_t                            mem_req_addr,
    output fetch_pkg::addr_t                            resp_pc,
    output fetch_pkg::inst_t                            resp_inst,
    output logic                                        q_write,
    output fetch_pkg::fetch_entry_t                     q_entry,
    output logic                                        q_kill
);

    localparam int count_bits = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic             running;
    logic             outstanding;
    logic             discard;
    fetch_pkg::addr_t req_pc;
    fetch_pkg::addr_t pend_pc;
    fetch_pkg::iid_t  iid;

    logic                  resp_fire;
    logic                  req_fire;
    logic                  room;
    logic [count_bits-1:0] occ_after;
    fetch_pkg::addr_t      next_addr;

    assign resp_fire = outstanding && mem_resp_valid;

    // redirect wins over a response in the same cycle
    assign q_write = resp_fire && !discard && !redirect.valid;
    assign q_kill  = redirect.valid;

    assign q_entry.addr    = req_pc;
    assign q_entry.inst    = mem_resp_inst;
    assign q_entry.inst_id = iid;

    assign resp_pc   = req_pc;
    assign resp_inst = mem_resp_inst;

    always_comb begin
        if (decode.is_jal) begin
            next_addr = decode.jal_target;
        end else if (decode.is_branch && predict_taken) begin
            next_addr = decode.br_target;
        end else begin
            next_addr = decode.seq_pc;
        end
    end

    // room left once this cycle's entry is in
    assign occ_after = queue_count + count_bits'(q_write);
    assign room      = (occ_after < count_bits'(`FETCH_QUEUE_DEPTH));

    assign mem_req_valid = running && (!outstanding || q_write) && room && !redirect.valid;
    assign mem_req_addr  = q_write ? next_addr : pend_pc;
    assign req_fire      = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            running     <= 1'b0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            pend_pc     <= `FETCH_RESET_PC;
            iid         <= '0;
        end else begin
            running <= 1'b1;
            if (redirect.valid) begin
                // a response still on its way gets dropped
                pend_pc     <= redirect.addr;
                outstanding <= outstanding && !mem_resp_valid;
                discard     <= outstanding && !mem_resp_valid;
            end else if (resp_fire && discard) begin
                outstanding <= 1'b0;
                discard     <= 1'b0;
            end else begin
                if (q_write) begin
                    pend_pc     <= next_addr;
                    iid         <= iid + 1'b1;
                    outstanding <= 1'b0;
                end
                if (req_fire) begin
                    outstanding <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= mem_req_addr;
        end
    end

    // single outstanding request, the next one waits for a response
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        req_fire |=> !mem_req_valid until mem_resp_valid
    ) else $error("fetch_ctrl: second request before response");

    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        q_write |-> (queue_count < count_bits'(`FETCH_QUEUE_DEPTH))
    ) else $error("fetch_ctrl: entry written into a full queue");

endmodule

// File: fetch/pre_decoder.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module pre_decoder (
    input  fetch_pkg::addr_t          pc,
    input  fetch_pkg::inst_t          inst,
    output fetch_pkg::decode_info_t   info
);

    logic [6:0]  opcode;
    logic [20:0] imm_j;
    logic [12:0] imm_b;
    logic [31:0] imm_j_sext;
    logic [31:0] imm_b_sext;

    assign opcode = inst[6:0];

    // J-type immediate, bit 0 is always zero
    assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // B-type immediate
    assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign imm_j_sext = {{11{imm_j[20]}}, imm_j};
    assign imm_b_sext = {{19{imm_b[12]}}, imm_b};

    assign info.is_jal     = (opcode == `OPCODE_JAL);
    assign info.is_branch  = (opcode == `OPCODE_BRANCH);
    assign info.jal_target = pc + imm_j_sext;
    assign info.br_target  = pc + imm_b_sext;
    assign info.seq_pc     = pc + 32'd4;

endmodule

// File: hw/bimodal_predictor.sv
`timescale 1ns/100ps
`include "fetch_config.svh"

module bimodal_predictor (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_pkg::addr_t        lookup_pc,
    input  fetch_pkg::br_update_t   update,
    output logic                    predict_taken
);

    localparam int entries = 1 << `BP_INDEX_BITS;

    logic [1:0] ctr [entries];

    logic [`BP_INDEX_BITS-1:0] lookup_idx;
    logic [`BP_INDEX_BITS-1:0] update_idx;
    logic [1:0]                upd_ctr;

    // word-aligned pcs, so skip the low two bits
    assign lookup_idx = lookup_pc[`BP_INDEX_BITS+1:2];
    assign update_idx = update.pc[`BP_INDEX_BITS+1:2];
    assign upd_ctr    = ctr[update_idx];

    // old counter value, a same-cycle update lands next cycle
    assign predict_taken = ctr[lookup_idx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            // weakly not taken
            for (int i = 0; i < entries; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (update.valid) begin
            if (update.taken) begin
                if (upd_ctr != 2'b11) begin
                    ctr[update_idx] <= upd_ctr + 2'b01;
                end
            end else begin
                if (upd_ctr != 2'b00) begin
                    ctr[update_idx] <= upd_ctr - 2'b01;
                end
            end
        end
    end

    // two taken updates in a row to one index always leave it predicting taken
    a_train_taken: assert property (
        @(posedge clk) disable iff (rst)
        (update.valid && update.taken)
            ##1 (update.valid && update.taken && $stable(update_idx))
            |=> ctr[$past(update_idx)][1]
    ) else $error("bimodal_predictor: counter failed to saturate upward");

endmodule

// File: hw/sync_queue.sv
`timescale 1ns/100ps

module sync_queue #(
    parameter int DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           kill,
    input  logic                           write,
    input  fetch_pkg::fetch_entry_t        wdata,
    input  logic                           read_ready,
    output logic                           read_valid,
    output fetch_pkg::fetch_entry_t        rdata,
    output logic [$clog2(DEPTH + 1)-1:0]   count
);

    localparam int ptr_bits = $clog2(DEPTH);
    localparam int count_bits = $clog2(DEPTH + 1);

    fetch_pkg::fetch_entry_t mem [DEPTH];

    logic [ptr_bits-1:0] wptr;
    logic [ptr_bits-1:0] rptr;
    logic                do_read;

    assign read_valid = (count != '0);
    assign do_read    = read_valid && read_ready;

    // head entry straight from the array, so a write shows up one cycle later
    assign rdata = mem[rptr];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own since DEPTH is a power of two
            if (write) begin
                wptr <= wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + count_bits'(write) - count_bits'(do_read);
        end
    end

    // the fetch side must hold off before the buffer fills
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        write |-> (count < count_bits'(DEPTH))
    ) else $error("sync_queue: write while full");

endmodule

// File: common/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // wraps around, only ordering matters downstream
    typedef logic [`FETCH_IID_BITS-1:0] iid_t;

    typedef struct packed {
        addr_t addr;
        inst_t inst;
        iid_t  inst_id;
    } fetch_entry_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
    } br_update_t;

    typedef struct packed {
        logic  is_jal;
        logic  is_branch;
        addr_t jal_target;
        addr_t br_target;
        addr_t seq_pc;
    } decode_info_t;

endpackage

// File: common/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// entries in the fetch queue, power of two
`define FETCH_QUEUE_DEPTH 8

`define FETCH_RESET_PC 32'h0000_0000
`define FETCH_IID_BITS 8

// 64 counters, indexed by pc[7:2]
`define BP_INDEX_BITS 6

`define OPCODE_JAL 7'b1101111
`define OPCODE_BRANCH 7'b1100011

`endif
